// ==== run.sh ====
#!/bin/sh
# Build and run the energy monitor testbench with Verilator.
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f \
    --top-module energy_monitor_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Venergy_monitor_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0

// ==== src/energy_accumulator.sv ====
// valid_i is the weight handshake, one cycle ahead of the registered local terms
`timescale 1ns/1ps
`include "ising_defines.svh"

module energy_accumulator (
    input  logic clk_i,
    input  logic rst_i,
    input  logic clear_i,
    input  logic valid_i,
    input  ising_types_pkg::local_energy_t [`ISING_PARALLELISM-1:0] local_i,
    output logic done_o,
    output ising_types_pkg::energy_t energy_o
);
    import ising_types_pkg::*;

    // one spare bit, the sum is twice the energy before halving
    logic signed [`ISING_ENERGY_BIT:0] beat_sum;
    logic signed [`ISING_ENERGY_BIT:0] acc_q;
    logic signed [`ISING_ENERGY_BIT:0] halved;
    logic valid_q;
    logic done_q;

    always_comb begin
        beat_sum = '0;
        for (int k = 0; k < `ISING_PARALLELISM; k++) begin
            beat_sum = beat_sum + $signed(local_i[k]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            acc_q <= '0;
            valid_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
            done_q <= valid_q;
            if (clear_i) begin
                acc_q <= '0;
            end else if (valid_q) begin
                acc_q <= acc_q + beat_sum;
            end
        end
    end

    assign done_o = done_q;

    // halve for the double count, negate since h is taken as negative
    assign halved = acc_q / 2;
    assign energy_o = energy_t'(-halved);

endmodule

// ==== src/energy_ctrl.sv ====
// job sequencer; a new spin vector is refused until the previous energy has been taken
`timescale 1ns/1ps

module energy_ctrl (
    input  logic clk_i,
    input  logic rst_i,
    input  logic config_valid_i,
    output logic config_ready_o,
    input  logic spin_valid_i,
    output logic spin_ready_o,
    input  logic weight_valid_i,
    output logic weight_ready_o,
    input  logic sweep_done_i,
    input  logic acc_done_i,
    input  logic energy_ready_i,
    output logic energy_valid_o,
    output logic acc_clear_o,
    output logic load_o,
    output logic recount_o,
    output logic step_o,
    output logic busy_o
);
    import energy_ctrl_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic spin_hs;
    logic energy_hs;

    assign config_ready_o = (state_q == IDLE);
    assign spin_ready_o = (state_q == IDLE);
    // sweep_done_i lags the last beat by a cycle, so close the channel on it
    assign weight_ready_o = (state_q == COMPUTE) && !sweep_done_i;
    assign energy_valid_o = (state_q == OUTPUT);
    assign busy_o = (state_q != IDLE);

    assign spin_hs = spin_valid_i && spin_ready_o;
    assign energy_hs = energy_valid_o && energy_ready_i;

    assign load_o = config_valid_i && config_ready_o;
    assign recount_o = spin_hs;
    assign step_o = weight_valid_i && weight_ready_o;
    assign acc_clear_o = energy_hs;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (spin_hs) begin
                    state_d = COMPUTE;
                end
            end
            COMPUTE: begin
                if (sweep_done_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // done here always belongs to the final beat
                if (acc_done_i) begin
                    state_d = OUTPUT;
                end
            end
            OUTPUT: begin
                if (energy_hs) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== src/energy_ctrl_pkg.sv ====
// controller state encoding; only one job is in flight at a time, so no state counts jobs
package energy_ctrl_pkg;

    // IDLE     config and spin channels open
    // COMPUTE  weight beats stream in
    // DRAIN    wait for the last beat to leave the accumulator
    // OUTPUT   energy presented until accepted
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        COMPUTE = 2'd1,
        DRAIN   = 2'd2,
        OUTPUT  = 2'd3
    } ctrl_state_t;

endpackage

// ==== src/energy_monitor.sv ====
// energy_o is only meaningful while energy_valid_o is high; config start must be a multiple of 4
`timescale 1ns/1ps
`include "ising_defines.svh"

module energy_monitor (
    input  logic clk_i,
    input  logic rst_i,
    input  logic config_valid_i,
    input  ising_types_pkg::row_idx_t config_counter_i,
    output logic config_ready_o,
    input  logic spin_valid_i,
    input  ising_types_pkg::spin_vec_t spin_i,
    output logic spin_ready_o,
    input  logic weight_valid_i,
    input  ising_types_pkg::weight_beat_t weight_i,
    output logic weight_ready_o,
    output logic energy_valid_o,
    output ising_types_pkg::energy_t energy_o,
    input  logic energy_ready_i,
    output logic busy_o
);
    import ising_types_pkg::*;

    logic load;
    logic recount;
    logic step;
    logic sweep_done;
    logic acc_done;
    logic acc_clear;
    row_idx_t row;
    spin_vec_t spins_cached;
    logic [`ISING_PARALLELISM-1:0] current_spin;
    local_energy_t [`ISING_PARALLELISM-1:0] local_terms;

    energy_ctrl u_energy_ctrl (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .config_valid_i(config_valid_i),
        .config_ready_o(config_ready_o),
        .spin_valid_i(spin_valid_i),
        .spin_ready_o(spin_ready_o),
        .weight_valid_i(weight_valid_i),
        .weight_ready_o(weight_ready_o),
        .sweep_done_i(sweep_done),
        .acc_done_i(acc_done),
        .energy_ready_i(energy_ready_i),
        .energy_valid_o(energy_valid_o),
        .acc_clear_o(acc_clear),
        .load_o(load),
        .recount_o(recount),
        .step_o(step),
        .busy_o(busy_o)
    );

    row_counter u_row_counter (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .load_i(load),
        .start_i(config_counter_i),
        .recount_i(recount),
        .step_i(step),
        .row_o(row),
        .sweep_done_o(sweep_done)
    );

    spin_cache u_spin_cache (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .capture_i(recount),
        .spin_i(spin_i),
        .row_i(row),
        .spins_o(spins_cached),
        .current_o(current_spin)
    );

    // one unit per row of the beat
    for (genvar k = 0; k < `ISING_PARALLELISM; k++) begin : gen_partial
        partial_energy_calc u_partial_energy_calc (
            .clk_i(clk_i),
            .rst_i(rst_i),
            .valid_i(step),
            .spins_i(spins_cached),
            .current_i(current_spin[k]),
            .row_i(weight_i.rows[k]),
            .hbias_i(weight_i.hbias[k]),
            .hscaling_i(weight_i.hscaling[k]),
            .energy_o(local_terms[k])
        );
    end

    energy_accumulator u_energy_accumulator (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .clear_i(acc_clear),
        .valid_i(step),
        .local_i(local_terms),
        .done_o(acc_done),
        .energy_o(energy_o)
    );

endmodule

// ==== src/ising_defines.svh ====
// one fixed size set (16 spins, 4 rows per beat); the derived widths are set by hand, keep them in step
`ifndef ISING_DEFINES_SVH
`define ISING_DEFINES_SVH

// problem size
`define ISING_NUM_SPIN 16
`define ISING_PARALLELISM 4

// data precision of the incoming weight beats
`define ISING_BITJ 4
`define ISING_BITH 4
`define ISING_SCALING_BIT 4

// final energy word
`define ISING_ENERGY_BIT 32

// clog2 of NUM_SPIN
`define ISING_SPINIDX_BIT 4

// index width + bias width + scaling width
`define ISING_LOCAL_BIT 12

`endif

// ==== src/ising_types_pkg.sv ====
// data types of the energy monitor; sizes come from ising_defines.svh and are not parameters
`include "ising_defines.svh"

package ising_types_pkg;

    // bit 1 is spin +1, bit 0 is spin -1
    typedef logic [`ISING_NUM_SPIN-1:0] spin_vec_t;

    typedef logic [`ISING_SPINIDX_BIT-1:0] row_idx_t;

    typedef logic signed [`ISING_BITJ-1:0] coupling_t;
    typedef logic signed [`ISING_BITH-1:0] bias_t;
    typedef logic [`ISING_SCALING_BIT-1:0] scaling_t;

    // element j is the coupling to spin j
    typedef coupling_t [`ISING_NUM_SPIN-1:0] weight_row_t;

    // entry k of every field belongs to matrix row (counter + k)
    typedef struct packed {
        weight_row_t [`ISING_PARALLELISM-1:0] rows;
        bias_t [`ISING_PARALLELISM-1:0] hbias;
        scaling_t [`ISING_PARALLELISM-1:0] hscaling;
    } weight_beat_t;

    typedef logic signed [`ISING_LOCAL_BIT-1:0] local_energy_t;
    typedef logic signed [`ISING_ENERGY_BIT-1:0] energy_t;

endpackage

// ==== src/partial_energy_calc.sv ====
// one row per cycle; the local width assumes 16 spins and 4-bit couplings, bias and scaling
`timescale 1ns/1ps
`include "ising_defines.svh"

module partial_energy_calc (
    input  logic clk_i,
    input  logic rst_i,
    input  logic valid_i,
    input  ising_types_pkg::spin_vec_t spins_i,
    input  logic current_i,
    input  ising_types_pkg::weight_row_t row_i,
    input  ising_types_pkg::bias_t hbias_i,
    input  ising_types_pkg::scaling_t hscaling_i,
    output ising_types_pkg::local_energy_t energy_o
);
    import ising_types_pkg::*;

    local_energy_t coupling_sum;
    local_energy_t scaled_bias;
    local_energy_t field;
    local_energy_t local_term;
    local_energy_t energy_q;

    // sum_j J_ij * sigma_j, spin bit 0 flips the coupling sign
    always_comb begin
        coupling_sum = '0;
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            if (spins_i[j]) begin
                coupling_sum = coupling_sum + $signed(row_i[j]);
            end else begin
                coupling_sum = coupling_sum - $signed(row_i[j]);
            end
        end
    end

    // scaling is unsigned, so pad a zero before the signed multiply
    assign scaled_bias = $signed(hbias_i) * $signed({1'b0, hscaling_i});

    // bias counted twice since the total is halved at the end
    assign field = coupling_sum + scaled_bias + scaled_bias;

    assign local_term = current_i ? field : -field;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            energy_q <= '0;
        end else if (valid_i) begin
            energy_q <= local_term;
        end
    end

    assign energy_o = energy_q;

endmodule

// ==== src/row_counter.sv ====
// start row must be a multiple of PARALLELISM, otherwise the wrap flag is never hit cleanly
`timescale 1ns/1ps
`include "ising_defines.svh"

module row_counter (
    input  logic clk_i,
    input  logic rst_i,
    input  logic load_i,
    input  ising_types_pkg::row_idx_t start_i,
    input  logic recount_i,
    input  logic step_i,
    output ising_types_pkg::row_idx_t row_o,
    output logic sweep_done_o
);
    import ising_types_pkg::*;

    row_idx_t start_q;
    row_idx_t row_q;
    logic sweep_done_q;
    // one extra bit to see the carry past NUM_SPIN-1
    logic [`ISING_SPINIDX_BIT:0] row_next;

    assign row_next = {1'b0, row_q} + (`ISING_SPINIDX_BIT + 1)'(`ISING_PARALLELISM);
    assign row_o = row_q;
    assign sweep_done_o = sweep_done_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_q <= '0;
            row_q <= '0;
            sweep_done_q <= 1'b0;
        end else begin
            if (load_i) begin
                start_q <= start_i;
            end
            if (recount_i) begin
                // a config in the same cycle belongs to this job
                row_q <= load_i ? start_i : start_q;
                sweep_done_q <= 1'b0;
            end else if (step_i) begin
                row_q <= row_next[`ISING_SPINIDX_BIT-1:0];
                if (row_next >= (`ISING_SPINIDX_BIT + 1)'(`ISING_NUM_SPIN)) begin
                    sweep_done_q <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/spin_cache.sv ====
// little-endian spin storage only; row_i + PARALLELISM must not pass NUM_SPIN
`timescale 1ns/1ps
`include "ising_defines.svh"

module spin_cache (
    input  logic clk_i,
    input  logic rst_i,
    input  logic capture_i,
    input  ising_types_pkg::spin_vec_t spin_i,
    input  ising_types_pkg::row_idx_t row_i,
    output ising_types_pkg::spin_vec_t spins_o,
    output logic [`ISING_PARALLELISM-1:0] current_o
);
    import ising_types_pkg::*;

    spin_vec_t spins_q;

    // held for the whole job, every row needs the full vector
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            spins_q <= '0;
        end else if (capture_i) begin
            spins_q <= spin_i;
        end
    end

    assign spins_o = spins_q;

    // bit k of the slice is the spin of matrix row (row_i + k)
    assign current_o = spins_q[row_i +: `ISING_PARALLELISM];

endmodule

// ==== test/tb_ref_model.svh ====
// software model of H; include inside a module that imports ising_types_pkg, halving truncates toward zero
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef coupling_t coupling_matrix_t [`ISING_NUM_SPIN][`ISING_NUM_SPIN];
typedef bias_t bias_vec_t [`ISING_NUM_SPIN];
typedef scaling_t scaling_vec_t [`ISING_NUM_SPIN];

// galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 32'h8020_0003;
    end
    return next;
endfunction

function automatic int spin_sign(input logic spin_bit);
    return spin_bit ? 1 : -1;
endfunction

// H = -(1/2 * sum_i sum_j s_i J_ij s_j + sum_i h_i c_i s_i) over rows start..NUM_SPIN-1
function automatic longint ref_energy(
    input spin_vec_t spins,
    input int start,
    input coupling_matrix_t jm,
    input bias_vec_t hv,
    input scaling_vec_t sv
);
    longint pair_sum;
    longint bias_sum;
    longint total;
    int si;
    pair_sum = 0;
    bias_sum = 0;
    for (int i = start; i < `ISING_NUM_SPIN; i++) begin
        si = spin_sign(spins[i]);
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            pair_sum = pair_sum + si * int'(jm[i][j]) * spin_sign(spins[j]);
        end
        bias_sum = bias_sum + int'(hv[i]) * int'(sv[i]) * si;
    end
    // bias doubled so one halving covers both sums
    total = pair_sum + 2 * bias_sum;
    return -(total / 2);
endfunction

`endif

// ==== test/energy_monitor_tb.sv ====
// runs 27 jobs on the fixed 16 spin, 4 row build; every job must end in one energy transfer
`timescale 1ns/1ps
`include "ising_defines.svh"

module energy_monitor_tb;
    import ising_types_pkg::*;

    `include "tb_ref_model.svh"

    localparam int NS = `ISING_NUM_SPIN;
    localparam int P = `ISING_PARALLELISM;
    localparam int RAND_JOBS = 20;
    localparam int HOLD_JOBS = 5;
    localparam int TOTAL_JOBS = 1 + RAND_JOBS + HOLD_JOBS + 1;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_JOBS + 100;
    // partial register, accumulator register, DRAIN
    localparam int LATENCY = 3;

    logic clk_i;
    logic rst_i;
    logic config_valid_i;
    row_idx_t config_counter_i;
    logic config_ready_o;
    logic spin_valid_i;
    spin_vec_t spin_i;
    logic spin_ready_o;
    logic weight_valid_i;
    weight_beat_t weight_i;
    logic weight_ready_o;
    logic energy_valid_o;
    energy_t energy_o;
    logic energy_ready_i;
    logic busy_o;

    logic [31:0] lfsr_state;
    spin_vec_t job_spins;
    coupling_matrix_t j_mat;
    bias_vec_t h_vec;
    scaling_vec_t s_vec;
    longint expected_q[$];
    string cur_test;
    int errors;
    int checks;
    int err_mark;
    int tests_run;
    int tests_failed;
    int jobs;
    int results;
    longint cycle_cnt;
    longint last_beat_cycle;
    longint held_energy;
    logic valid_seen;

    energy_monitor energy_monitor_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    task automatic check_value(input string what, input longint expected, input longint actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("error in %s: expected %0d, got %0d", what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
        tests_run++;
    endtask

    task automatic end_test();
        check_value({cur_test, " result count"}, jobs, results);
        if (errors == err_mark) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - err_mark);
        end
    endtask

    // all ones when rnd is low, otherwise LFSR data
    task automatic build_job(input int start, input logic rnd);
        job_spins = rnd ? spin_vec_t'(take_bits(NS)) : '1;
        for (int i = 0; i < NS; i++) begin
            for (int j = 0; j < NS; j++) begin
                j_mat[i][j] = rnd ? coupling_t'(take_bits(`ISING_BITJ)) : coupling_t'(1);
            end
            h_vec[i] = rnd ? bias_t'(take_bits(`ISING_BITH)) : bias_t'(1);
            s_vec[i] = rnd ? scaling_t'(take_bits(`ISING_SCALING_BIT)) : scaling_t'(1);
        end
        expected_q.push_back(ref_energy(job_spins, start, j_mat, h_vec, s_vec));
        jobs++;
    endtask

    function automatic weight_beat_t make_beat(input int first_row);
        weight_beat_t beat;
        for (int k = 0; k < P; k++) begin
            for (int j = 0; j < NS; j++) begin
                beat.rows[k][j] = j_mat[first_row + k][j];
            end
            beat.hbias[k] = h_vec[first_row + k];
            beat.hscaling[k] = s_vec[first_row + k];
        end
        return beat;
    endfunction

    // entered and left just after a falling edge
    task automatic run_job(input int start, input logic gaps, input logic hold_on,
                           input logic with_config);
        int gap;
        int hold;
        spin_i = job_spins;
        spin_valid_i = 1'b1;
        if (with_config) begin
            config_counter_i = row_idx_t'(start);
            config_valid_i = 1'b1;
        end
        do @(posedge clk_i); while (!spin_ready_o);
        @(negedge clk_i);
        spin_valid_i = 1'b0;
        config_valid_i = 1'b0;
        for (int b = 0; b < (NS - start) / P; b++) begin
            gap = gaps ? int'(take_bits(2)) : 0;
            repeat (gap) @(negedge clk_i);
            weight_i = make_beat(start + b * P);
            weight_valid_i = 1'b1;
            do @(posedge clk_i); while (!weight_ready_o);
            @(negedge clk_i);
            weight_valid_i = 1'b0;
        end
        hold = hold_on ? int'(take_bits(4)) + 1 : 0;
        while (!energy_valid_o) @(negedge clk_i);
        // a pending spin must wait for the energy transfer
        spin_valid_i = hold_on;
        repeat (hold) @(negedge clk_i);
        energy_ready_i = 1'b1;
        @(negedge clk_i);
        energy_ready_i = 1'b0;
        spin_valid_i = 1'b0;
    endtask

    // catches each energy transfer and checks latency and hold behavior
    always @(posedge clk_i) begin
        if (!rst_i) begin
            cycle_cnt++;
            if (weight_valid_i && weight_ready_o) begin
                last_beat_cycle = cycle_cnt;
            end
            if (energy_valid_o) begin
                if (!valid_seen) begin
                    check_value({cur_test, " latency"}, LATENCY, cycle_cnt - last_beat_cycle);
                    held_energy = energy_o;
                    valid_seen = 1'b1;
                end
                check_value({cur_test, " energy hold"}, held_energy, energy_o);
                check_value({cur_test, " spin_ready during output"}, 0, spin_ready_o);
                check_value({cur_test, " config_ready during output"}, 0, config_ready_o);
                check_value({cur_test, " busy during output"}, 1, busy_o);
                if (energy_ready_i) begin
                    valid_seen = 1'b0;
                    results++;
                    if (expected_q.size() == 0) begin
                        errors++;
                        $display("energy transfer in %s with no job pending", cur_test);
                    end else begin
                        check_value({cur_test, " energy"}, expected_q.pop_front(), energy_o);
                    end
                end
            end
        end
    end

    initial begin
        rst_i = 1'b1;
        config_valid_i = 1'b0;
        config_counter_i = '0;
        spin_valid_i = 1'b0;
        spin_i = '0;
        weight_valid_i = 1'b0;
        weight_i = '0;
        energy_ready_i = 1'b0;
        lfsr_state = 32'h3dd0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        jobs = 0;
        results = 0;
        cycle_cnt = 0;
        last_beat_cycle = 0;
        held_energy = 0;
        valid_seen = 1'b0;
        cur_test = "reset";
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;

        begin_test("reset state");
        check_value("reset state config_ready", 1, config_ready_o);
        check_value("reset state spin_ready", 1, spin_ready_o);
        check_value("reset state weight_ready", 0, weight_ready_o);
        check_value("reset state energy_valid", 0, energy_valid_o);
        check_value("reset state busy", 0, busy_o);
        end_test();

        begin_test("all ones");
        build_job(0, 1'b0);
        check_value("all ones model", -(256 / 2 + 16), expected_q[0]);
        run_job(0, 1'b0, 1'b0, 1'b0);
        end_test();

        begin_test("random jobs");
        for (int n = 0; n < RAND_JOBS; n++) begin
            build_job(0, 1'b1);
            run_job(0, 1'b1, 1'b0, 1'b0);
        end
        end_test();

        begin_test("energy backpressure");
        for (int n = 0; n < HOLD_JOBS; n++) begin
            build_job(0, 1'b1);
            run_job(0, 1'b1, 1'b1, 1'b0);
        end
        end_test();

        // config and spin share one handshake edge here
        begin_test("start row 8");
        build_job(8, 1'b1);
        run_job(8, 1'b1, 1'b0, 1'b1);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
+incdir+test
src/ising_types_pkg.sv
src/energy_ctrl_pkg.sv
src/energy_ctrl.sv
src/row_counter.sv
src/spin_cache.sv
src/partial_energy_calc.sv
src/energy_accumulator.sv
src/energy_monitor.sv
test/energy_monitor_tb.sv
